//--- ooo_mux.f
+incdir+common
+incdir+dv
common/ooo_mux_pkg.sv
design/ooo_req_arbiter.sv
design/ooo_resp_router.sv
mem_backend/ooo_mem_backend.sv
design/ooo_mux_top.sv
dv/ooo_mux_tb.sv

//--- Bender.yml
package:
  name: ooo_mux

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ooo_mux_pkg.sv
      - design/ooo_req_arbiter.sv
      - design/ooo_resp_router.sv
      - mem_backend/ooo_mem_backend.sv
      - design/ooo_mux_top.sv
  - target: test
    include_dirs:
      - common
      - dv
    files:
      - dv/ooo_mux_tb.sv

//--- dv/ooo_mux_tests.svh
//**************************************************************************
// directed tests of the out-of-order request funnel
// single channel, all channels, round-robin, forced priority,
// out-of-order completion under back-pressure
//**************************************************************************

`ifndef OOO_MUX_TESTS_SVH
`define OOO_MUX_TESTS_SVH

// channels in the order the arbiter accepted them
int accept_order [$];

// no response for 8 cycles means every slot is free again
task automatic wait_idle(input string test);
  int quiet;
  int waited;
  quiet  = 0;
  waited = 0;
  while (quiet < 8) begin
    @(negedge clk_i);
    quiet = (resp_valid_o == '0) ? quiet + 1 : 0;
    waited++;
    if (waited > WAIT_LIMIT) begin
      abort_run($sformatf("%s: responses never drained", test));
    end
  end
endtask

// every channel writes continuously and drops out after per_chan accepts
task automatic collect_accept_order(input int per_chan, input string test);
  int cnt [NB_CHAN];
  int ch;
  int waited;
  accept_order.delete();
  @(posedge clk_i);
  for (int i = 0; i < NB_CHAN; i++) begin
    cnt[i] = 0;
    req_valid_i[i] <= 1'b1;
    req_wen_i[i]   <= 1'b1;
    // low bits zero, shortest latency
    req_addr_i[i]  <= addr_t'(32 + 4 * i);
    req_wdata_i[i] <= data_t'($urandom);
  end
  waited = 0;
  while (accept_order.size() < per_chan * NB_CHAN) begin
    @(negedge clk_i);
    ch = -1;
    for (int i = 0; i < NB_CHAN; i++) begin
      if (req_valid_i[i] && req_ready_o[i]) begin
        ch = i;
      end
    end
    waited++;
    if (waited > WAIT_LIMIT) begin
      abort_run($sformatf("%s: arbiter stopped accepting requests", test));
    end
    @(posedge clk_i);
    if (ch >= 0) begin
      accept_order.push_back(ch);
      ref_mem[req_addr_i[ch]] = req_wdata_i[ch];
      cnt[ch]++;
      if (cnt[ch] == per_chan) begin
        req_valid_i[ch] <= 1'b0;
      end
    end
  end
endtask

task automatic test_single_channel();
  addr_t addr;
  data_t wdata;
  addr  = addr_t'($urandom);
  wdata = data_t'($urandom);
  chan_transfer(0, 1'b1, addr, wdata, 1'b1, "single_channel");
  chan_transfer(0, 1'b0, addr, '0, 1'b1, "single_channel");
  wait_idle("single_channel");
endtask

task automatic test_all_channels();
  addr_t base;
  addr_t addr [NB_CHAN];
  data_t wdata [NB_CHAN];
  base = addr_t'($urandom);
  for (int i = 0; i < NB_CHAN; i++) begin
    // stride 17 keeps the words apart and mixes the latencies
    addr[i]  = base + addr_t'(17 * i);
    wdata[i] = data_t'($urandom);
  end
  fork
    chan_transfer(0, 1'b1, addr[0], wdata[0], 1'b0, "all_channels");
    chan_transfer(1, 1'b1, addr[1], wdata[1], 1'b0, "all_channels");
    chan_transfer(2, 1'b1, addr[2], wdata[2], 1'b0, "all_channels");
    chan_transfer(3, 1'b1, addr[3], wdata[3], 1'b0, "all_channels");
  join
  fork
    chan_transfer(0, 1'b0, addr[0], '0, 1'b0, "all_channels");
    chan_transfer(1, 1'b0, addr[1], '0, 1'b0, "all_channels");
    chan_transfer(2, 1'b0, addr[2], '0, 1'b0, "all_channels");
    chan_transfer(3, 1'b0, addr[3], '0, 1'b0, "all_channels");
  join
  wait_idle("all_channels");
endtask

task automatic test_round_robin();
  @(posedge clk_i);
  clear_i <= 1'b1;
  @(posedge clk_i);
  clear_i <= 1'b0;
  collect_accept_order(2, "round_robin");
  // pointer restarts at channel 0 after clear
  for (int k = 0; k < 2 * NB_CHAN; k++) begin
    check_value("round_robin", $sformatf("accept %0d", k), k % NB_CHAN, accept_order[k]);
  end
  wait_idle("round_robin");
endtask

task automatic test_forced_priority();
  int exp_order [4] = '{1, 3, 0, 2};
  @(posedge clk_i);
  priority_force_i <= 1'b1;
  // channel 1 highest, channel 2 lowest
  priority_i[0] <= chan_id_t'(1);
  priority_i[1] <= chan_id_t'(3);
  priority_i[2] <= chan_id_t'(0);
  priority_i[3] <= chan_id_t'(2);
  collect_accept_order(1, "forced_priority");
  for (int k = 0; k < 4; k++) begin
    check_value("forced_priority", $sformatf("accept %0d", k), exp_order[k], accept_order[k]);
  end
  wait_idle("forced_priority");
  @(posedge clk_i);
  priority_force_i <= 1'b0;
endtask

task automatic test_out_of_order();
  string name = "out_of_order";
  addr_t addr_slow;
  addr_t addr_fast;
  data_t exp_slow;
  data_t exp_fast;
  int    waited;
  // low bits 3 count down longest, low bits 0 answer next cycle
  addr_slow = addr_t'($urandom) | addr_t'(3);
  addr_fast = addr_t'($urandom) & ~addr_t'(3);
  chan_transfer(0, 1'b1, addr_slow, data_t'($urandom), 1'b0, name);
  chan_transfer(1, 1'b1, addr_fast, data_t'($urandom), 1'b0, name);
  @(posedge clk_i);
  resp_ready_i[0] <= 1'b0;
  issue_req(0, 1'b0, addr_slow, '0, name, exp_slow);
  issue_req(1, 1'b0, addr_fast, '0, name, exp_fast);
  // short read overtakes the long one
  wait_resp(1, 1'b0, exp_fast, 1'b0, name);
  waited = 0;
  do begin
    @(negedge clk_i);
    waited++;
    if (waited > WAIT_LIMIT) begin
      abort_run("out_of_order: stalled response of channel 0 never appeared");
    end
  end while (!resp_valid_o[0]);
  // held by channel 0, must not move
  for (int k = 0; k < 4; k++) begin
    check_value(name, "stalled valid", 1'b1, resp_valid_o[0]);
    check_value(name, "stalled data", exp_slow, resp_data_o[0]);
    @(negedge clk_i);
  end
  @(posedge clk_i);
  resp_ready_i[0] <= 1'b1;
  wait_resp(0, 1'b0, exp_slow, 1'b0, name);
  wait_idle(name);
endtask

`endif

//--- dv/ooo_mux_tb.sv
//**************************************************************************
// testbench top of the out-of-order request funnel
// clock, reset, DUT, reference memory, compare task, channel drivers
//**************************************************************************

`timescale 1ns/10ps
`default_nettype none

`include "ooo_mux_config.svh"

module ooo_mux_tb;

  import ooo_mux_pkg::*;

  // cycles any single wait may take
  localparam int WAIT_LIMIT = 200;

  logic                    clk_i = 1'b0;
  logic                    rst_ni;
  logic                    clear_i;
  logic                    priority_force_i;
  chan_id_t  [NB_CHAN-1:0] priority_i;
  logic      [NB_CHAN-1:0] req_valid_i;
  logic      [NB_CHAN-1:0] req_ready_o;
  addr_t     [NB_CHAN-1:0] req_addr_i;
  logic      [NB_CHAN-1:0] req_wen_i;
  data_t     [NB_CHAN-1:0] req_wdata_i;
  logic      [NB_CHAN-1:0] resp_valid_o;
  logic      [NB_CHAN-1:0] resp_ready_i;
  data_t     [NB_CHAN-1:0] resp_data_o;
  resp_opc_t [NB_CHAN-1:0] resp_opc_o;

  // expected scratchpad contents
  data_t ref_mem [2**AW];

  ooo_mux_top dut0 (.*);

  // 40 ns period
  always #20 clk_i = ~clk_i;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s %s expected 0x%0h actual 0x%0h",
                          test, what, exp, act));
    end
  endtask

  // holds one request until accepted and returns the word expected on a read
  task automatic issue_req(input int ch, input logic wen, input addr_t addr,
                           input data_t wdata, input string test,
                           output data_t exp_data);
    int waited;
    @(posedge clk_i);
    req_valid_i[ch] <= 1'b1;
    req_wen_i[ch]   <= wen;
    req_addr_i[ch]  <= addr;
    req_wdata_i[ch] <= wdata;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run($sformatf("%s: request of channel %0d was never accepted", test, ch));
      end
    end while (!req_ready_o[ch]);
    // backend writes or samples the word at the coming edge
    if (wen) begin
      ref_mem[addr] = wdata;
    end
    exp_data = ref_mem[addr];
    @(posedge clk_i);
    req_valid_i[ch] <= 1'b0;
  endtask

  // waits for the response on one channel and checks opcode and read data
  task automatic wait_resp(input int ch, input logic wen, input data_t exp_data,
                           input logic solo, input string test);
    logic [NB_CHAN-1:0] others;
    int                 waited;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run($sformatf("%s: no response arrived on channel %0d", test, ch));
      end
    end while (!resp_valid_o[ch]);
    check_value(test, "opcode", wen ? OPC_WACK : OPC_RDATA, resp_opc_o[ch]);
    if (!wen) begin
      check_value(test, "read data", exp_data, resp_data_o[ch]);
    end
    if (solo) begin
      others     = resp_valid_o;
      others[ch] = 1'b0;
      check_value(test, "valid on other channels", '0, others);
    end
  endtask

  task automatic chan_transfer(input int ch, input logic wen, input addr_t addr,
                               input data_t wdata, input logic solo, input string test);
    data_t exp_data;
    issue_req(ch, wen, addr, wdata, test, exp_data);
    wait_resp(ch, wen, exp_data, solo, test);
  endtask

  `include "ooo_mux_tests.svh"

  initial begin
    // one seed for every random value of the run
    void'($urandom(73));
    rst_ni           = 1'b0;
    clear_i          = 1'b0;
    priority_force_i = 1'b0;
    priority_i       = '0;
    req_valid_i      = '0;
    req_wen_i        = '0;
    req_addr_i       = '0;
    req_wdata_i      = '0;
    resp_ready_i     = '1;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_single_channel();
    test_all_channels();
    test_round_robin();
    test_forced_priority();
    test_out_of_order();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/ooo_mux_top.sv
//**************************************************************************
// top level of the out-of-order request funnel
// arbiter, scratchpad backend and response router
//**************************************************************************

`timescale 1ns/10ps
`default_nettype none

`include "ooo_mux_config.svh"

module ooo_mux_top (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         clear_i,
  input  logic                                         priority_force_i,
  input  ooo_mux_pkg::chan_id_t  [`OOO_NB_CHAN-1:0]    priority_i,
  input  logic                   [`OOO_NB_CHAN-1:0]    req_valid_i,
  output logic                   [`OOO_NB_CHAN-1:0]    req_ready_o,
  input  ooo_mux_pkg::addr_t     [`OOO_NB_CHAN-1:0]    req_addr_i,
  input  logic                   [`OOO_NB_CHAN-1:0]    req_wen_i,
  input  ooo_mux_pkg::data_t     [`OOO_NB_CHAN-1:0]    req_wdata_i,
  output logic                   [`OOO_NB_CHAN-1:0]    resp_valid_o,
  input  logic                   [`OOO_NB_CHAN-1:0]    resp_ready_i,
  output ooo_mux_pkg::data_t     [`OOO_NB_CHAN-1:0]    resp_data_o,
  output ooo_mux_pkg::resp_opc_t [`OOO_NB_CHAN-1:0]    resp_opc_o
);

  import ooo_mux_pkg::*;

  // merged request towards the backend
  logic      mreq_valid;
  logic      mreq_ready;
  logic      mreq_wen;
  addr_t     mreq_addr;
  data_t     mreq_wdata;
  chan_id_t  mreq_id;

  // tagged response towards the router
  logic      mresp_valid;
  logic      mresp_ready;
  data_t     mresp_data;
  resp_opc_t mresp_opc;
  chan_id_t  mresp_id;

  ooo_req_arbiter i_arbiter (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .clear_i          (clear_i),
    .priority_force_i (priority_force_i),
    .priority_i       (priority_i),
    .req_valid_i      (req_valid_i),
    .req_wen_i        (req_wen_i),
    .req_addr_i       (req_addr_i),
    .req_wdata_i      (req_wdata_i),
    .req_ready_o      (req_ready_o),
    .mreq_valid_o     (mreq_valid),
    .mreq_wen_o       (mreq_wen),
    .mreq_addr_o      (mreq_addr),
    .mreq_wdata_o     (mreq_wdata),
    .mreq_id_o        (mreq_id),
    .mreq_ready_i     (mreq_ready)
  );

  ooo_mem_backend i_backend (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .mreq_valid_i  (mreq_valid),
    .mreq_wen_i    (mreq_wen),
    .mreq_addr_i   (mreq_addr),
    .mreq_wdata_i  (mreq_wdata),
    .mreq_id_i     (mreq_id),
    .mreq_ready_o  (mreq_ready),
    .mresp_valid_o (mresp_valid),
    .mresp_data_o  (mresp_data),
    .mresp_opc_o   (mresp_opc),
    .mresp_id_o    (mresp_id),
    .mresp_ready_i (mresp_ready)
  );

  ooo_resp_router i_router (
    .mresp_valid_i (mresp_valid),
    .mresp_data_i  (mresp_data),
    .mresp_opc_i   (mresp_opc),
    .mresp_id_i    (mresp_id),
    .mresp_ready_o (mresp_ready),
    .resp_valid_o  (resp_valid_o),
    .resp_data_o   (resp_data_o),
    .resp_opc_o    (resp_opc_o),
    .resp_ready_i  (resp_ready_i)
  );

endmodule

`default_nettype wire

//--- mem_backend/ooo_mem_backend.sv
//**************************************************************************
// scratchpad backend with out-of-order completion
// word array, slot table with address-dependent countdown,
// lowest-eligible response select with hold under back-pressure
//**************************************************************************

`timescale 1ns/10ps
`default_nettype none

`include "ooo_mux_config.svh"

module ooo_mem_backend (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   mreq_valid_i,
  input  logic                   mreq_wen_i,
  input  ooo_mux_pkg::addr_t     mreq_addr_i,
  input  ooo_mux_pkg::data_t     mreq_wdata_i,
  input  ooo_mux_pkg::chan_id_t  mreq_id_i,
  output logic                   mreq_ready_o,
  output logic                   mresp_valid_o,
  output ooo_mux_pkg::data_t     mresp_data_o,
  output ooo_mux_pkg::resp_opc_t mresp_opc_o,
  output ooo_mux_pkg::chan_id_t  mresp_id_o,
  input  logic                   mresp_ready_i
);

  import ooo_mux_pkg::*;

  localparam int unsigned NB_SLOTS  = `OOO_NB_SLOTS;
  localparam int unsigned SLOT_IDW  = (NB_SLOTS > 1) ? $clog2(NB_SLOTS) : 1;
  localparam int unsigned MEM_WORDS = 2 ** AW;

  // scratchpad words
  data_t     mem_q [MEM_WORDS];

  // slot table, control part
  logic      [NB_SLOTS-1:0] busy_q;
  logic      [1:0]          cnt_q [NB_SLOTS];
  // slot table, payload part
  chan_id_t  id_q   [NB_SLOTS];
  resp_opc_t opc_q  [NB_SLOTS];
  data_t     data_q [NB_SLOTS];

  logic      [NB_SLOTS-1:0] eligible;
  logic      [SLOT_IDW-1:0] free_idx;
  logic      [SLOT_IDW-1:0] elig_idx;
  logic      [SLOT_IDW-1:0] sel_d;
  logic      [SLOT_IDW-1:0] sel_q;
  logic                     hold_q;
  logic                     accept;
  logic                     resp_xfer;

  // countdown done means ready to answer
  for (genvar s = 0; s < NB_SLOTS; s++) begin : gen_elig
    assign eligible[s] = busy_q[s] & (cnt_q[s] == 2'd0);
  end

  // lowest free and lowest eligible slot, scanned downwards
  always_comb begin
    free_idx = '0;
    elig_idx = '0;
    for (int s = NB_SLOTS - 1; s >= 0; s--) begin
      if (!busy_q[s]) begin
        free_idx = SLOT_IDW'(s);
      end
      if (eligible[s]) begin
        elig_idx = SLOT_IDW'(s);
      end
    end
  end

  assign mreq_ready_o = ~&busy_q;
  assign accept       = mreq_valid_i & mreq_ready_o;

  // a stalled response keeps its slot even if a lower one gets ready
  assign sel_d         = hold_q ? sel_q : elig_idx;
  assign mresp_valid_o = |eligible;
  assign mresp_data_o  = data_q[sel_d];
  assign mresp_opc_o   = opc_q[sel_d];
  assign mresp_id_o    = id_q[sel_d];
  assign resp_xfer     = mresp_valid_o & mresp_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= '0;
      hold_q <= 1'b0;
      sel_q  <= '0;
      for (int s = 0; s < NB_SLOTS; s++) begin
        cnt_q[s] <= 2'd0;
      end
    end else if (clear_i) begin
      busy_q <= '0;
      hold_q <= 1'b0;
      sel_q  <= '0;
      for (int s = 0; s < NB_SLOTS; s++) begin
        cnt_q[s] <= 2'd0;
      end
    end else begin
      hold_q <= mresp_valid_o & ~mresp_ready_i;
      sel_q  <= sel_d;
      // running countdowns
      for (int s = 0; s < NB_SLOTS; s++) begin
        if (busy_q[s] && cnt_q[s] != 2'd0) begin
          cnt_q[s] <= cnt_q[s] - 2'd1;
        end
      end
      if (resp_xfer) begin
        busy_q[sel_d] <= 1'b0;
      end
      // latency picked by the low address bits
      if (accept) begin
        busy_q[free_idx] <= 1'b1;
        cnt_q[free_idx]  <= mreq_addr_i[1:0];
      end
    end
  end

  // memory and slot payload, write and read both at acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q[free_idx] <= mreq_id_i;
      if (mreq_wen_i) begin
        mem_q[mreq_addr_i] <= mreq_wdata_i;
        opc_q[free_idx]    <= OPC_WACK;
        data_q[free_idx]   <= '0;
      end else begin
        opc_q[free_idx]    <= OPC_RDATA;
        data_q[free_idx]   <= mem_q[mreq_addr_i];
      end
    end
  end

  // an accepted request always lands in a slot, so the table was not full
  a_no_accept_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (accept && !clear_i) |=>
      $countones(busy_q) == $past($countones(busy_q)) + 1 - $past(resp_xfer))
    else $error("request accepted without a free slot");

  // presented response frozen while the tagged channel stalls
  a_resp_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mresp_valid_o && !mresp_ready_i && !clear_i) |=>
      mresp_valid_o && $stable(mresp_id_o) && $stable(mresp_data_o) && $stable(mresp_opc_o))
    else $error("response changed under back-pressure");

endmodule

`default_nettype wire

//--- design/ooo_resp_router.sv
//**************************************************************************
// response router of the out-of-order funnel
// tag decode to per-channel valid, broadcast payload, ready select
//**************************************************************************

`timescale 1ns/10ps
`default_nettype none

`include "ooo_mux_config.svh"

module ooo_resp_router (
  input  logic                                         mresp_valid_i,
  input  ooo_mux_pkg::data_t                           mresp_data_i,
  input  ooo_mux_pkg::resp_opc_t                       mresp_opc_i,
  input  ooo_mux_pkg::chan_id_t                        mresp_id_i,
  output logic                                         mresp_ready_o,
  output logic                   [`OOO_NB_CHAN-1:0]    resp_valid_o,
  output ooo_mux_pkg::data_t     [`OOO_NB_CHAN-1:0]    resp_data_o,
  output ooo_mux_pkg::resp_opc_t [`OOO_NB_CHAN-1:0]    resp_opc_o,
  input  logic                   [`OOO_NB_CHAN-1:0]    resp_ready_i
);

  import ooo_mux_pkg::*;

  for (genvar i = 0; i < NB_CHAN; i++) begin : gen_chan
    // payload goes to every channel
    assign resp_data_o[i] = mresp_data_i;
    assign resp_opc_o[i]  = mresp_opc_i;
    // only the tagged channel sees valid
    assign resp_valid_o[i] = mresp_valid_i & (mresp_id_i == chan_id_t'(i));
  end

  // back-pressure comes from the tagged channel alone
  assign mresp_ready_o = resp_ready_i[mresp_id_i];

endmodule

`default_nettype wire

//--- design/ooo_req_arbiter.sv
//**************************************************************************
// request arbiter of the out-of-order funnel
// round-robin or forced-priority selection, winner hold until accepted,
// request mux with channel tag
//**************************************************************************

`timescale 1ns/10ps
`default_nettype none

`include "ooo_mux_config.svh"

module ooo_req_arbiter (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         clear_i,
  input  logic                                         priority_force_i,
  input  ooo_mux_pkg::chan_id_t [`OOO_NB_CHAN-1:0]     priority_i,
  input  logic                  [`OOO_NB_CHAN-1:0]     req_valid_i,
  input  logic                  [`OOO_NB_CHAN-1:0]     req_wen_i,
  input  ooo_mux_pkg::addr_t    [`OOO_NB_CHAN-1:0]     req_addr_i,
  input  ooo_mux_pkg::data_t    [`OOO_NB_CHAN-1:0]     req_wdata_i,
  output logic                  [`OOO_NB_CHAN-1:0]     req_ready_o,
  output logic                                         mreq_valid_o,
  output logic                                         mreq_wen_o,
  output ooo_mux_pkg::addr_t                           mreq_addr_o,
  output ooo_mux_pkg::data_t                           mreq_wdata_o,
  output ooo_mux_pkg::chan_id_t                        mreq_id_o,
  input  logic                                         mreq_ready_i
);

  import ooo_mux_pkg::*;

  chan_id_t rr_ptr_q;
  chan_id_t winner_d;
  chan_id_t winner_q;
  logic     xfer_d;
  logic     xfer_q;
  logic     any_req_q;
  logic     reeval;

  // first requester at or after the pointer
  function automatic chan_id_t rr_pick(input logic [NB_CHAN-1:0] valid, input chan_id_t ptr);
    chan_id_t win;
    int       idx;
    win = ptr;
    // walk backwards so the smallest offset is assigned last
    for (int k = NB_CHAN - 1; k >= 0; k--) begin
      idx = (int'(ptr) + k) % NB_CHAN;
      if (valid[idx]) begin
        win = chan_id_t'(idx);
      end
    end
    return win;
  endfunction

  // largest priority wins, strict compare leaves ties to the lower index
  function automatic chan_id_t prio_pick(input logic [NB_CHAN-1:0] valid,
                                         input chan_id_t [NB_CHAN-1:0] prio,
                                         input chan_id_t ptr);
    chan_id_t win;
    chan_id_t best;
    logic     found;
    win   = ptr;
    best  = '0;
    found = 1'b0;
    for (int k = 0; k < NB_CHAN; k++) begin
      if (valid[k] && (!found || prio[k] > best)) begin
        win   = chan_id_t'(k);
        best  = prio[k];
        found = 1'b1;
      end
    end
    return win;
  endfunction

  // output handshake of the merged port
  assign xfer_d = mreq_valid_o & mreq_ready_i;

  // a new choice only after a handshake or an idle cycle
  assign reeval = xfer_q | ~any_req_q;

  always_comb begin
    winner_d = winner_q;
    if (reeval) begin
      if (priority_force_i) begin
        winner_d = prio_pick(req_valid_i, priority_i, rr_ptr_q);
      end else begin
        winner_d = rr_pick(req_valid_i, rr_ptr_q);
      end
    end
  end

  // pointer, held winner and the two history flags
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_ptr_q  <= '0;
      winner_q  <= '0;
      xfer_q    <= 1'b0;
      any_req_q <= 1'b0;
    end else if (clear_i) begin
      rr_ptr_q  <= '0;
      winner_q  <= '0;
      xfer_q    <= 1'b0;
      any_req_q <= 1'b0;
    end else begin
      winner_q  <= winner_d;
      xfer_q    <= xfer_d;
      any_req_q <= |req_valid_i;
      // pointer goes to the channel after the winner
      if (xfer_d) begin
        if (winner_d == chan_id_t'(NB_CHAN - 1)) begin
          rr_ptr_q <= '0;
        end else begin
          rr_ptr_q <= winner_d + chan_id_t'(1);
        end
      end
    end
  end

  // winning request onto the memory side, tagged with its index
  assign mreq_valid_o = req_valid_i[winner_d];
  assign mreq_wen_o   = req_wen_i[winner_d];
  assign mreq_addr_o  = req_addr_i[winner_d];
  assign mreq_wdata_o = req_wdata_i[winner_d];
  assign mreq_id_o    = winner_d;

  for (genvar i = 0; i < NB_CHAN; i++) begin : gen_ready
    assign req_ready_o[i] = (winner_d == chan_id_t'(i)) & mreq_ready_i;
  end

  // a stalled request keeps its channel until accepted
  a_hold_winner : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mreq_valid_o && !mreq_ready_i && !clear_i) |=> $stable(mreq_id_o))
    else $error("arbiter switched channel under back-pressure");

endmodule

`default_nettype wire

//--- common/ooo_mux_pkg.sv
//**************************************************************************
// shared package of the out-of-order request funnel
// widths derived from the config header, tag and payload types,
// response opcode enum
//**************************************************************************

`default_nettype none

`include "ooo_mux_config.svh"

package ooo_mux_pkg;

  localparam int unsigned NB_CHAN = `OOO_NB_CHAN;
  // tag width, kept at one bit for a single channel
  localparam int unsigned CHAN_IDW = (NB_CHAN > 1) ? $clog2(NB_CHAN) : 1;
  localparam int unsigned AW = `OOO_AW;
  localparam int unsigned DW = `OOO_DW;

  // index of the originating channel
  typedef logic [CHAN_IDW-1:0] chan_id_t;
  typedef logic [AW-1:0] addr_t;
  typedef logic [DW-1:0] data_t;

  // response kind returned with every completion
  typedef enum logic {
    OPC_RDATA = 1'b0,
    OPC_WACK  = 1'b1
  } resp_opc_t;

endpackage

`default_nettype wire

//--- common/ooo_mux_config.svh
//**************************************************************************
// size defines of the out-of-order request funnel
// channel count, word address and data widths, backend slot count
//**************************************************************************

`ifndef OOO_MUX_CONFIG_SVH
`define OOO_MUX_CONFIG_SVH

// number of initiator channels
`define OOO_NB_CHAN 4

// word address width, 64 words by default
`define OOO_AW 6

// data word width
`define OOO_DW 32

// outstanding requests held by the backend
`define OOO_NB_SLOTS 4

`endif
